//--- lfo_trace.txt
# T name | W addr data resp | R addr data resp | S strobes(dec) noise | E lfa lfp
# hex except strobes; noise byte enters on the last 8 strobes, msb first
T regs
# restart preloads from the previous LFRQ, so LFRQ is written twice
W 0 F0 0
W 0 F0 0
W 4 55 0
W 8 2A 0
W C 2 0
R 0 F0 0
R 4 55 0
R 8 2A 0
R C 2 0
R 2 0 2
W 6 FF 2
R 4 55 0
T rate
W C 0 0
W 4 40 0
W 8 0 0
E 7F 00
S 32 00
E 7E 00
S 64 00
E 7C 00
W 0 E0 0
W 0 E0 0
S 64 00
E 7B 00
S 64 00
E 7A 00
T update
W 8 7F 0
S 8 00
E 7A 09
W 0 F0 0
W 0 F0 0
S 15 00
E 7A 09
S 1 00
E 7A 0A
T waves
W 4 7F 0
E F2 0A
W C 1 0
E FC 7E
W C 2 0
E E6 0A
S 1920 00
E 05 82
W C 1 0
E 00 FE
W C 0 0
E 7B 82
S 1024 00
W C 2 0
E 84 BB
T noise
W C 3 0
S 16 B5
E B2 B4
S 32 4C
E 4B 4B
T depth
W 8 0 0
E 4B 00
W C 0 0
E 37 00
W C 1 0
E 00 00
W C 2 0
E 8A 00
W 4 20 0
E 23 00
W 4 1 0
E 01 00
W 4 55 0
E 5C 00
R 8 0 0

//--- list.f
+incdir+.
lfo_pkg.sv
lfo_regs.sv
lfo_rate_divider.sv
lfo_phase_gen.sv
lfo_depth_scaler.sv
lfo_top.sv
tb_lfo.sv

//--- run_sim.sh
#!/bin/sh
# build and run the LFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_lfo -o sim_lfo
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_lfo > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

grep -q "^STATUS: PASS$" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

exit 0

//--- tb_lfo_axi_tasks.svh
`ifndef TB_LFO_AXI_TASKS_SVH
`define TB_LFO_AXI_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// compare and count

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
        $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        errors    = errors + 1;
        test_errs = test_errs + 1;
    end
endtask

//////////////////////////////////////////////////////////////////////
// AXI4-Lite master side

// address and data raised together, held until the slave takes them
task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                         input logic [1:0] exp_resp);
    int delay;
    @(negedge i_EMUCLK);
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awaddr  = addr;
    i_wdata   = data;
    i_wstrb   = 4'h1;
    #1;
    while (!(o_awready && o_wready)) begin
        @(negedge i_EMUCLK);
        #1;
    end
    @(negedge i_EMUCLK);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    // random B back-pressure, bvalid has to hold meanwhile
    delay = $urandom % 4;
    repeat (delay) @(negedge i_EMUCLK);
    check_value("o_bvalid", {31'd0, o_bvalid}, 32'd1);
    check_value("o_bresp", {30'd0, o_bresp}, {30'd0, exp_resp});
    i_bready = 1'b1;
    @(negedge i_EMUCLK);
    i_bready = 1'b0;
endtask

task automatic axi_read(input logic [3:0] addr, input logic [31:0] exp_data,
                        input logic [1:0] exp_resp);
    int delay;
    @(negedge i_EMUCLK);
    i_arvalid = 1'b1;
    i_araddr  = addr;
    #1;
    while (!o_arready) begin
        @(negedge i_EMUCLK);
        #1;
    end
    @(negedge i_EMUCLK);
    i_arvalid = 1'b0;
    delay = $urandom % 4;
    repeat (delay) @(negedge i_EMUCLK);
    check_value("o_rvalid", {31'd0, o_rvalid}, 32'd1);
    check_value("o_rdata", o_rdata, exp_data);
    check_value("o_rresp", {30'd0, o_rresp}, {30'd0, exp_resp});
    i_rready = 1'b1;
    @(negedge i_EMUCLK);
    i_rready = 1'b0;
endtask

`endif

//--- tb_lfo.sv
`timescale 1ns/1ps

module tb_lfo;

    localparam int    SETTLE     = 3;
    localparam string TRACE_FILE = "lfo_trace.txt";

    logic           i_EMUCLK;
    logic           mrst_n;
    logic           i_awvalid, o_awready, i_wvalid, o_wready;
    logic [3:0]     i_awaddr, i_araddr;
    logic [31:0]    i_wdata, o_rdata;
    logic [3:0]     i_wstrb;
    logic           o_bvalid, i_bready, i_arvalid, o_arready, o_rvalid, i_rready;
    logic [1:0]     o_bresp, o_rresp;
    logic           i_sample_en, i_lfo_noise;
    logic [7:0]     o_lfa, o_lfp;

    int     cycles = 0;
    int     cycle_limit = 0;
    int     errors = 0;
    int     checks = 0;
    int     test_errs = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    string  test_name = "";

    lfo_top #(.PRESCALE_DIV(16)) uut (
        .i_EMUCLK (i_EMUCLK), .mrst_n (mrst_n),
        .i_awvalid (i_awvalid), .o_awready (o_awready), .i_awaddr (i_awaddr),
        .i_wvalid (i_wvalid), .o_wready (o_wready), .i_wdata (i_wdata),
        .i_wstrb (i_wstrb), .o_bvalid (o_bvalid), .i_bready (i_bready),
        .o_bresp (o_bresp), .i_arvalid (i_arvalid), .o_arready (o_arready),
        .i_araddr (i_araddr), .o_rvalid (o_rvalid), .i_rready (i_rready),
        .o_rdata (o_rdata), .o_rresp (o_rresp), .i_sample_en (i_sample_en),
        .i_lfo_noise (i_lfo_noise), .o_lfa (o_lfa), .o_lfp (o_lfp)
    );

    `include "tb_lfo_axi_tasks.svh"

    initial begin
        i_EMUCLK = 1'b0;
        forever #20 i_EMUCLK = ~i_EMUCLK;
    end

    // watchdog, limit set once the trace has been scanned
    always @(posedge i_EMUCLK) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: trace not finished within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers

    // strobes held high, pattern lands in the last 8 slots msb first
    task automatic run_strobes(input int count, input logic [7:0] pattern);
        for (int i = 0; i < count; i++) begin
            @(negedge i_EMUCLK);
            i_sample_en = 1'b1;
            i_lfo_noise = (i >= count - 8) ? pattern[count-1-i] : 1'b0;
        end
        @(negedge i_EMUCLK);
        i_sample_en = 1'b0;
        i_lfo_noise = 1'b0;
    endtask

    task automatic end_test();
        if (test_name != "") begin
            tests_run = tests_run + 1;
            if (test_errs != 0) tests_failed = tests_failed + 1;
            $display("test %s: %s (%0d errors)", test_name,
                     (test_errs == 0) ? "ok" : "failed", test_errs);
        end
        test_errs = 0;
    endtask

    // first pass sizes the watchdog
    task automatic size_timeout(input int fd);
        string cmd, line;
        int    count;
        logic [31:0] a;
        cycle_limit = 200;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%s", cmd));
            if (cmd == "W" || cmd == "R") cycle_limit = cycle_limit + 40;
            if (cmd == "S") begin
                void'($sscanf(line, "%s %d %h", cmd, count, a));
                cycle_limit = cycle_limit + count;
            end
        end
    endtask

    task automatic play_trace(input int fd);
        string cmd, line, name;
        int    count;
        logic [31:0] a, b, c;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%s", cmd));
            case (cmd)
                "T": begin
                    end_test();
                    void'($sscanf(line, "%s %s", cmd, name));
                    test_name = name;
                end
                "W": begin
                    void'($sscanf(line, "%s %h %h %h", cmd, a, b, c));
                    axi_write(a[3:0], b, c[1:0]);
                end
                "R": begin
                    void'($sscanf(line, "%s %h %h %h", cmd, a, b, c));
                    axi_read(a[3:0], b, c[1:0]);
                end
                "S": begin
                    void'($sscanf(line, "%s %d %h", cmd, count, a));
                    run_strobes(count, a[7:0]);
                end
                "E": begin
                    void'($sscanf(line, "%s %h %h", cmd, a, b));
                    repeat (SETTLE) @(posedge i_EMUCLK);
                    @(negedge i_EMUCLK);
                    check_value("o_lfa", {24'd0, o_lfa}, a);
                    check_value("o_lfp", {24'd0, o_lfp}, b);
                end
                default: begin
                    $display("Trace line not understood: %s", line);
                    errors    = errors + 1;
                    test_errs = test_errs + 1;
                end
            endcase
        end
        end_test();
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int fd;
        void'($urandom(32'hcfeb_8421));
        mrst_n = 1'b0;
        i_awvalid = 1'b0;
        i_wvalid = 1'b0;
        i_awaddr = '0;
        i_wdata = '0;
        i_wstrb = '0;
        i_bready = 1'b0;
        i_arvalid = 1'b0;
        i_araddr = '0;
        i_rready = 1'b0;
        i_sample_en = 1'b0;
        i_lfo_noise = 1'b0;
        repeat (4) @(posedge i_EMUCLK);
        @(negedge i_EMUCLK);
        mrst_n = 1'b1;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            $display("STATUS: FAIL");
        end else begin
            size_timeout(fd);
            $fclose(fd);
            fd = $fopen(TRACE_FILE, "r");
            play_trace(fd);
            $fclose(fd);
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     tests_run, tests_failed, checks, errors);
            if (errors == 0 && tests_failed == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
        end
        $finish;
    end

endmodule

//--- lfo_top.sv
`timescale 1ns/1ps

module lfo_top #(
    parameter int PRESCALE_DIV = 16
) (
    input  logic                                i_EMUCLK,
    input  logic                                mrst_n,

    // AXI4-Lite slave
    input  logic                                i_awvalid,
    output logic                                o_awready,
    input  logic [lfo_pkg::AXI_ADDR_W-1:0]      i_awaddr,
    input  logic                                i_wvalid,
    output logic                                o_wready,
    input  logic [lfo_pkg::AXI_DATA_W-1:0]      i_wdata,
    input  logic [lfo_pkg::AXI_DATA_W/8-1:0]    i_wstrb,
    output logic                                o_bvalid,
    input  logic                                i_bready,
    output logic [1:0]                          o_bresp,
    input  logic                                i_arvalid,
    output logic                                o_arready,
    input  logic [lfo_pkg::AXI_ADDR_W-1:0]      i_araddr,
    output logic                                o_rvalid,
    input  logic                                i_rready,
    output logic [lfo_pkg::AXI_DATA_W-1:0]      o_rdata,
    output logic [1:0]                          o_rresp,

    // sample slot strobe and serial noise
    input  logic                                i_sample_en,
    input  logic                                i_lfo_noise,

    output logic [lfo_pkg::OUT_W-1:0]           o_lfa,
    output logic [lfo_pkg::OUT_W-1:0]           o_lfp
);

    logic [lfo_pkg::LFRQ_W-1:0]     lfrq;
    logic [lfo_pkg::DEPTH_W-1:0]    amd;
    logic [lfo_pkg::DEPTH_W-1:0]    pmd;
    lfo_pkg::wave_e                 wave;
    logic                           freq_update;
    logic                           lfo_tick;
    logic [lfo_pkg::DEPTH_W-1:0]    am_base;
    logic                           pm_sign;
    logic [lfo_pkg::DEPTH_W-1:0]    pm_mag;

    //////////////////////////////////////////////////////////////////////
    // register block

    lfo_regs u_regs (
        .i_EMUCLK      (i_EMUCLK),
        .mrst_n        (mrst_n),
        .i_awvalid     (i_awvalid),
        .o_awready     (o_awready),
        .i_awaddr      (i_awaddr),
        .i_wvalid      (i_wvalid),
        .o_wready      (o_wready),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .o_bvalid      (o_bvalid),
        .i_bready      (i_bready),
        .o_bresp       (o_bresp),
        .i_arvalid     (i_arvalid),
        .o_arready     (o_arready),
        .i_araddr      (i_araddr),
        .o_rvalid      (o_rvalid),
        .i_rready      (i_rready),
        .o_rdata       (o_rdata),
        .o_rresp       (o_rresp),
        .o_lfrq        (lfrq),
        .o_amd         (amd),
        .o_pmd         (pmd),
        .o_wave        (wave),
        .o_freq_update (freq_update)
    );

    //////////////////////////////////////////////////////////////////////
    // oscillator datapath

    // only the coarse nibble sets the rate
    lfo_rate_divider #(
        .PRESCALE_DIV (PRESCALE_DIV)
    ) u_rate_divider (
        .i_EMUCLK      (i_EMUCLK),
        .mrst_n        (mrst_n),
        .i_sample_en   (i_sample_en),
        .i_lfrq_coarse (lfrq[7:4]),
        .i_freq_update (freq_update),
        .o_lfo_tick    (lfo_tick)
    );

    lfo_phase_gen u_phase_gen (
        .i_EMUCLK    (i_EMUCLK),
        .mrst_n      (mrst_n),
        .i_sample_en (i_sample_en),
        .i_lfo_tick  (lfo_tick),
        .i_lfo_noise (i_lfo_noise),
        .i_wave      (wave),
        .o_am_base   (am_base),
        .o_pm_sign   (pm_sign),
        .o_pm_mag    (pm_mag)
    );

    lfo_depth_scaler u_depth_scaler (
        .i_EMUCLK  (i_EMUCLK),
        .mrst_n    (mrst_n),
        .i_am_base (am_base),
        .i_pm_sign (pm_sign),
        .i_pm_mag  (pm_mag),
        .i_amd     (amd),
        .i_pmd     (pmd),
        .o_lfa     (o_lfa),
        .o_lfp     (o_lfp)
    );

endmodule

//--- lfo_depth_scaler.sv
`timescale 1ns/1ps

module lfo_depth_scaler (
    input  logic                            i_EMUCLK,
    input  logic                            mrst_n,
    input  logic [lfo_pkg::DEPTH_W-1:0]     i_am_base,
    input  logic                            i_pm_sign,
    input  logic [lfo_pkg::DEPTH_W-1:0]     i_pm_mag,
    input  logic [lfo_pkg::DEPTH_W-1:0]     i_amd,
    input  logic [lfo_pkg::DEPTH_W-1:0]     i_pmd,
    output logic [lfo_pkg::OUT_W-1:0]       o_lfa,
    output logic [lfo_pkg::OUT_W-1:0]       o_lfp
);

    //////////////////////////////////////////////////////////////////////
    // depth multipliers

    // 7x7 products, full width
    logic [2*lfo_pkg::DEPTH_W-1:0]  am_prod;
    logic [2*lfo_pkg::DEPTH_W-1:0]  pm_prod;
    logic [lfo_pkg::OUT_W-1:0]      lfa_next;
    logic [lfo_pkg::OUT_W-1:0]      lfp_next;

    assign am_prod = i_am_base * i_amd;
    assign pm_prod = i_pm_mag * i_pmd;

    // AMD as 1.6 fixed point, peak 127*127>>6 still fits a byte
    assign lfa_next = am_prod[13:6];

    // sign and magnitude, PMD is a 0.7 fraction
    // PMD of zero forces a clean zero, no negative zero
    assign lfp_next = (i_pmd == '0) ? '0 : {i_pm_sign, pm_prod[13:7]};

    //////////////////////////////////////////////////////////////////////
    // output registers

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_lfa <= '0;
            o_lfp <= '0;
        end else begin
            o_lfa <= lfa_next;
            o_lfp <= lfp_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    // PM off for two cycles means LFP is settled at zero
    a_lfp_zero: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        (i_pmd == '0) ##1 (i_pmd == '0) |-> (o_lfp == '0));

endmodule

//--- lfo_phase_gen.sv
`timescale 1ns/1ps

module lfo_phase_gen (
    input  logic                            i_EMUCLK,
    input  logic                            mrst_n,
    input  logic                            i_sample_en,
    input  logic                            i_lfo_tick,
    input  logic                            i_lfo_noise,
    input  lfo_pkg::wave_e                  i_wave,
    output logic [lfo_pkg::DEPTH_W-1:0]     o_am_base,
    output logic                            o_pm_sign,
    output logic [lfo_pkg::DEPTH_W-1:0]     o_pm_mag
);

    //////////////////////////////////////////////////////////////////////
    // phase and noise capture

    logic [lfo_pkg::PHASE_W-1:0]    phase;
    logic [lfo_pkg::PHASE_W-1:0]    noise_sr;
    logic [lfo_pkg::PHASE_W-1:0]    noise_z;
    logic [lfo_pkg::DEPTH_W-1:0]    am_next;
    logic                           pm_sign_next;
    logic [lfo_pkg::DEPTH_W-1:0]    pm_mag_next;

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            phase    <= '0;
            noise_sr <= '0;
            noise_z  <= '0;
        end else begin
            // serial noise, newest bit in the lsb
            if (i_sample_en) begin
                noise_sr <= {noise_sr[lfo_pkg::PHASE_W-2:0], i_lfo_noise};
            end
            // one phase step per tick, noise byte sampled alongside
            if (i_lfo_tick) begin
                phase   <= phase + 1'b1;
                noise_z <= noise_sr;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // waveform shaping

    always_comb begin
        // saw by default
        am_next      = 7'd127 - phase[7:1];
        pm_sign_next = phase[7];
        pm_mag_next  = phase[6:0];
        case (i_wave)
            lfo_pkg::WAVE_SQUARE: begin
                am_next     = phase[7] ? 7'd0 : 7'd127;
                pm_mag_next = 7'd127;
            end
            lfo_pkg::WAVE_TRI: begin
                // falling half then rising half for AM
                am_next     = phase[7] ? phase[6:0] : 7'd127 - phase[6:0];
                pm_mag_next = phase[6] ? 7'd127 - phase[6:0] : phase[6:0];
            end
            lfo_pkg::WAVE_NOISE: begin
                am_next      = noise_z[7:1];
                pm_sign_next = noise_z[7];
                pm_mag_next  = noise_z[6:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_am_base <= '0;
            o_pm_sign <= 1'b0;
            o_pm_mag  <= '0;
        end else begin
            o_am_base <= am_next;
            o_pm_sign <= pm_sign_next;
            o_pm_mag  <= pm_mag_next;
        end
    end

endmodule

//--- lfo_rate_divider.sv
`timescale 1ns/1ps

module lfo_rate_divider #(
    parameter int PRESCALE_DIV = 16
) (
    input  logic        i_EMUCLK,
    input  logic        mrst_n,
    input  logic        i_sample_en,
    input  logic [3:0]  i_lfrq_coarse,
    input  logic        i_freq_update,
    output logic        o_lfo_tick
);

    localparam int PS_W = (PRESCALE_DIV > 1) ? $clog2(PRESCALE_DIV) : 1;

    //////////////////////////////////////////////////////////////////////
    // prescaler

    logic [PS_W-1:0]            ps_cnt;
    logic                       ps_wrap;
    logic [lfo_pkg::DIV_W-1:0]  div_cnt;
    logic [lfo_pkg::DIV_W-1:0]  preload;
    logic                       div_ovf;

    // last strobe of a prescaler round
    assign ps_wrap = i_sample_en && (ps_cnt == PS_W'(PRESCALE_DIV - 1));

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            ps_cnt <= '0;
        end else if (i_freq_update || ps_wrap) begin
            // restart clears the partial round too
            ps_cnt <= '0;
        end else if (i_sample_en) begin
            ps_cnt <= ps_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // 15-bit preloaded divider

    assign preload = lfo_pkg::div_preload(i_lfrq_coarse);

    // carry out of the all-ones state
    assign div_ovf = ps_wrap && (&div_cnt);

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            div_cnt    <= '0;
            o_lfo_tick <= 1'b0;
        end else begin
            // tick lands one cycle after the overflow
            o_lfo_tick <= div_ovf & ~i_freq_update;
            if (i_freq_update || div_ovf) begin
                div_cnt <= preload;
            end else if (ps_wrap) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    // every tick comes from a prescaler wrap
    a_tick_from_wrap: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        o_lfo_tick |-> $past(ps_wrap));

endmodule

//--- lfo_regs.sv
`timescale 1ns/1ps

module lfo_regs (
    input  logic                                i_EMUCLK,
    input  logic                                mrst_n,

    // write address and data channels
    input  logic                                i_awvalid,
    output logic                                o_awready,
    input  logic [lfo_pkg::AXI_ADDR_W-1:0]      i_awaddr,
    input  logic                                i_wvalid,
    output logic                                o_wready,
    input  logic [lfo_pkg::AXI_DATA_W-1:0]      i_wdata,
    input  logic [lfo_pkg::AXI_DATA_W/8-1:0]    i_wstrb,

    // write response channel
    output logic                                o_bvalid,
    input  logic                                i_bready,
    output logic [1:0]                          o_bresp,

    // read channels
    input  logic                                i_arvalid,
    output logic                                o_arready,
    input  logic [lfo_pkg::AXI_ADDR_W-1:0]      i_araddr,
    output logic                                o_rvalid,
    input  logic                                i_rready,
    output logic [lfo_pkg::AXI_DATA_W-1:0]      o_rdata,
    output logic [1:0]                          o_rresp,

    // register contents
    output logic [lfo_pkg::LFRQ_W-1:0]          o_lfrq,
    output logic [lfo_pkg::DEPTH_W-1:0]         o_amd,
    output logic [lfo_pkg::DEPTH_W-1:0]         o_pmd,
    output lfo_pkg::wave_e                      o_wave,
    output logic                                o_freq_update
);

    //////////////////////////////////////////////////////////////////////
    // write path

    logic                               wr_en;
    logic                               wr_lane;
    logic                               wr_err;
    logic [lfo_pkg::AXI_DATA_W-1:0]     rd_data;
    logic                               rd_err;

    // address and data taken together, blocked while B is pending
    assign wr_en     = i_awvalid & i_wvalid & ~o_bvalid;
    assign o_awready = wr_en;
    assign o_wready  = wr_en;
    // only byte lane 0 carries register bits
    assign wr_lane   = wr_en & i_wstrb[0];

    assign wr_err = !(i_awaddr inside {lfo_pkg::ADDR_LFRQ, lfo_pkg::ADDR_AMD,
                                       lfo_pkg::ADDR_PMD, lfo_pkg::ADDR_W});

    // divider restart, same cycle as the accepted LFRQ write
    assign o_freq_update = wr_lane && (i_awaddr == lfo_pkg::ADDR_LFRQ);

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_lfrq   <= '0;
            o_amd    <= '0;
            o_pmd    <= '0;
            o_wave   <= lfo_pkg::WAVE_SAW;
            o_bvalid <= 1'b0;
        end else begin
            if (wr_lane) begin
                case (i_awaddr)
                    lfo_pkg::ADDR_LFRQ: o_lfrq <= i_wdata[lfo_pkg::LFRQ_W-1:0];
                    lfo_pkg::ADDR_AMD:  o_amd  <= i_wdata[lfo_pkg::DEPTH_W-1:0];
                    lfo_pkg::ADDR_PMD:  o_pmd  <= i_wdata[lfo_pkg::DEPTH_W-1:0];
                    lfo_pkg::ADDR_W:    o_wave <= lfo_pkg::wave_e'(i_wdata[lfo_pkg::WAVE_W-1:0]);
                    // unmapped, dropped
                    default: ;
                endcase
            end
            // response pending until the master takes it
            if (wr_en) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (wr_en) begin
            o_bresp <= wr_err ? lfo_pkg::RESP_SLVERR : lfo_pkg::RESP_OKAY;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read path

    // one read in flight at a time
    assign o_arready = i_arvalid & ~o_rvalid;

    // readback mux, zero for unmapped
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (i_araddr)
            lfo_pkg::ADDR_LFRQ: rd_data[lfo_pkg::LFRQ_W-1:0]  = o_lfrq;
            lfo_pkg::ADDR_AMD:  rd_data[lfo_pkg::DEPTH_W-1:0] = o_amd;
            lfo_pkg::ADDR_PMD:  rd_data[lfo_pkg::DEPTH_W-1:0] = o_pmd;
            lfo_pkg::ADDR_W:    rd_data[lfo_pkg::WAVE_W-1:0]  = o_wave;
            default:            rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_rvalid <= 1'b0;
        end else if (o_arready) begin
            o_rvalid <= 1'b1;
        end else if (i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (o_arready) begin
            o_rdata <= rd_data;
            o_rresp <= rd_err ? lfo_pkg::RESP_SLVERR : lfo_pkg::RESP_OKAY;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    // B held until taken
    a_bvalid_hold: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        o_bvalid && !i_bready |=> o_bvalid);

    // restart strobe is a single cycle
    a_freq_update_pulse: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        o_freq_update |=> !o_freq_update);

endmodule

//--- lfo_pkg.sv
package lfo_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths

    // frequency register, LFRQ[7:4] coarse and LFRQ[3:0] fine
    localparam int LFRQ_W  = 8;
    // AMD and PMD
    localparam int DEPTH_W = 7;
    localparam int WAVE_W  = 2;
    // rate divider
    localparam int DIV_W   = 15;
    // phase counter and captured noise byte
    localparam int PHASE_W = 8;
    // LFA and LFP
    localparam int OUT_W   = 8;

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite register map

    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] ADDR_LFRQ = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] ADDR_AMD  = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] ADDR_PMD  = 4'h8;
    localparam logic [AXI_ADDR_W-1:0] ADDR_W    = 4'hC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // waveform select, W register
    typedef enum logic [WAVE_W-1:0] {
        WAVE_SAW    = 2'd0,
        WAVE_SQUARE = 2'd1,
        WAVE_TRI    = 2'd2,
        WAVE_NOISE  = 2'd3
    } wave_e;

    // divider preload from the coarse nibble
    // divider counts up from here to all ones, so a larger preload is a faster LFO
    function automatic logic [DIV_W-1:0] div_preload(input logic [3:0] n);
        logic [DIV_W:0] span;
        span = 16'h8000 - (16'h0001 << (4'd15 - n));
        // nibble 0 is the odd one out
        if (n == 4'd0) begin
            return 15'h1000;
        end
        return span[DIV_W-1:0];
    endfunction

endpackage
